/* rtl/flow_cfg_pkg.sv */
`default_nettype none

package flow_cfg_pkg;

  // field widths
  localparam int seq_w     = 32;  // seq or ack number
  localparam int ts_w      = 64;  // free-running timestamp
  localparam int flow_id_w = 22;  // id from the flow table
  localparam int addr_w    = 10;  // low id bits index the history RAMs

  // history lengths per direction
  localparam int tx_hist_len = 2;
  localparam int rx_hist_len = 3;

  // fifo depths as log2
  localparam int state_fifo_depth_bits = 8;
  localparam int id_fifo_depth_bits    = 4;  // lookups arrive slower than state words
  localparam int snap_fifo_depth_bits  = 6;

endpackage

`default_nettype wire

/* rtl/flow_types_pkg.sv */
`default_nettype none

package flow_types_pkg;

  // flow table lookup result
  typedef struct packed {
    logic                                 match;
    logic [flow_cfg_pkg::flow_id_w-1:0]   id;
  } lookup_t;

  // tx history, index 0 is the newest entry
  typedef struct packed {
    logic [flow_cfg_pkg::tx_hist_len-1:0][flow_cfg_pkg::ts_w-1:0]  ts;
    logic [flow_cfg_pkg::tx_hist_len-1:0][flow_cfg_pkg::seq_w-1:0] seq;
  } tx_hist_t;

  // rx history, same layout with ack numbers
  typedef struct packed {
    logic [flow_cfg_pkg::rx_hist_len-1:0][flow_cfg_pkg::ts_w-1:0]  ts;
    logic [flow_cfg_pkg::rx_hist_len-1:0][flow_cfg_pkg::seq_w-1:0] ack;
  } rx_hist_t;

  // both histories of one flow
  typedef struct packed {
    logic [flow_cfg_pkg::flow_id_w-1:0] id;
    tx_hist_t                           tx;
    rx_hist_t                           rx;
  } snapshot_t;

  // updater fsm
  typedef enum logic [2:0] {
    upd_idle,
    upd_read0,
    upd_read1,
    upd_write,
    upd_drop   // unmatched pair being popped
  } upd_state_e;

  // snapshot reader fsm
  typedef enum logic [1:0] {
    snap_idle,
    snap_read0,
    snap_read1,
    snap_emit
  } snap_state_e;

endpackage

`default_nettype wire

/* rtl/sync_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
  parameter int width      = 32,
  parameter int depth_bits = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_en,
  input  logic [width-1:0] din,
  input  logic             rd_en,
  output logic [width-1:0] dout,
  output logic             empty
);

  logic [width-1:0]      mem [2**depth_bits];
  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic [depth_bits:0]   count;
  logic                  full;
  logic                  push;
  logic                  pop;

  assign full  = count[depth_bits];  // msb only set at exactly 2**depth_bits
  assign empty = (count == '0);
  assign push  = wr_en && !full;
  assign pop   = rd_en && !empty;

  // first word falls through
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= din;
  end

  // source has no back-pressure, so overflow means lost data
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full)
    else $error("fifo push while full");

  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty)
    else $error("fifo pop while empty");

endmodule

`default_nettype wire

/* rtl/history_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module history_ram #(
  parameter int width = 192
) (
  input  logic                            clk,
  input  logic                            a_we,
  input  logic [flow_cfg_pkg::addr_w-1:0] a_addr,
  input  logic [width-1:0]                a_din,
  output logic [width-1:0]                a_dout,
  input  logic [flow_cfg_pkg::addr_w-1:0] b_addr,
  output logic [width-1:0]                b_dout
);

  logic [width-1:0] mem [2**flow_cfg_pkg::addr_w];

  // unseen flows read back as an empty history
  initial begin
    for (int i = 0; i < 2**flow_cfg_pkg::addr_w; i++) begin
      mem[i] = '0;
    end
  end

  // port A: read-modify-write side, read before write
  always_ff @(posedge clk) begin
    a_dout <= mem[a_addr];
    if (a_we) mem[a_addr] <= a_din;
  end

  // port B: read only, for snapshots
  always_ff @(posedge clk) begin
    b_dout <= mem[b_addr];
  end

endmodule

`default_nettype wire

/* rtl/history_updater.sv */
`timescale 1ns/100ps
`default_nettype none

module history_updater #(
  parameter  int hist_len = flow_cfg_pkg::tx_hist_len,
  localparam int hist_w   = hist_len * (flow_cfg_pkg::seq_w + flow_cfg_pkg::ts_w)
) (
  input  logic                               clk,
  input  logic                               rst_n,

  // head of the lookup and state fifos
  input  flow_types_pkg::lookup_t            lookup,
  input  logic                               lookup_empty,
  input  logic [flow_cfg_pkg::seq_w-1:0]     state_word,
  input  logic                               state_empty,
  output logic                               pop,  // pops both fifos together

  input  logic [flow_cfg_pkg::ts_w-1:0]      ts,

  // port A of the history ram
  output logic                               ram_we,
  output logic [flow_cfg_pkg::addr_w-1:0]    ram_addr,
  output logic [hist_w-1:0]                  ram_din,
  input  logic [hist_w-1:0]                  ram_dout,

  output logic                               done_vld,
  output logic [flow_cfg_pkg::flow_id_w-1:0] done_id
);

  // same layout as tx_hist_t and rx_hist_t, sized by hist_len
  typedef struct packed {
    logic [hist_len-1:0][flow_cfg_pkg::ts_w-1:0]  ts;
    logic [hist_len-1:0][flow_cfg_pkg::seq_w-1:0] word;
  } hist_t;

  flow_types_pkg::upd_state_e state;
  hist_t                      old_hist;
  hist_t                      new_hist;
  logic                       pair_rdy;

  // pairing is by arrival order, so both heads must be present
  assign pair_rdy = !lookup_empty && !state_empty;

  assign old_hist = ram_dout;

  // age every entry by one, oldest falls off the top
  always_comb begin
    new_hist.word = {old_hist.word[hist_len-2:0], state_word};
    new_hist.ts   = {old_hist.ts[hist_len-2:0], ts};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= flow_types_pkg::upd_idle;
      pop      <= 1'b0;
      ram_we   <= 1'b0;
      done_vld <= 1'b0;
    end else begin
      pop      <= 1'b0;
      ram_we   <= 1'b0;
      done_vld <= 1'b0;
      case (state)
        flow_types_pkg::upd_idle: begin
          if (pair_rdy) begin
            if (lookup.match) begin
              state <= flow_types_pkg::upd_read0;  // addr goes out this edge
            end else begin
              pop   <= 1'b1;  // discard pair, ram untouched
              state <= flow_types_pkg::upd_drop;
            end
          end
        end
        flow_types_pkg::upd_read0: begin
          state <= flow_types_pkg::upd_read1;  // ram latching addr
        end
        flow_types_pkg::upd_read1: begin
          pop      <= 1'b1;  // old history valid now
          ram_we   <= 1'b1;
          done_vld <= 1'b1;
          state    <= flow_types_pkg::upd_write;
        end
        flow_types_pkg::upd_write: begin
          state <= flow_types_pkg::upd_idle;
        end
        flow_types_pkg::upd_drop: begin
          state <= flow_types_pkg::upd_idle;
        end
        default: begin
          state <= flow_types_pkg::upd_idle;
        end
      endcase
    end
  end

  // address and write data
  always_ff @(posedge clk) begin
    if (state == flow_types_pkg::upd_idle) begin
      ram_addr <= lookup.id[flow_cfg_pkg::addr_w-1:0];
    end
    if (state == flow_types_pkg::upd_read1) begin
      ram_din <= new_hist;
      done_id <= lookup.id;  // full id, not just the ram index
    end
  end

endmodule

`default_nettype wire

/* rtl/snapshot_reader.sv */
`timescale 1ns/100ps
`default_nettype none

module snapshot_reader (
  input  logic                               clk,
  input  logic                               rst_n,

  // snapshot id fifo head
  input  logic [flow_cfg_pkg::flow_id_w-1:0] id,
  input  logic                               id_empty,
  output logic                               pop,

  // port B of both rams
  output logic [flow_cfg_pkg::addr_w-1:0]    rd_addr,
  input  flow_types_pkg::tx_hist_t           tx_dout,
  input  flow_types_pkg::rx_hist_t           rx_dout,

  output logic                               snap_vld,
  output flow_types_pkg::snapshot_t          snap
);

  flow_types_pkg::snap_state_e state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= flow_types_pkg::snap_idle;
      pop      <= 1'b0;
      snap_vld <= 1'b0;
    end else begin
      pop      <= 1'b0;
      snap_vld <= 1'b0;
      case (state)
        flow_types_pkg::snap_idle: begin
          if (!id_empty) state <= flow_types_pkg::snap_read0;
        end
        flow_types_pkg::snap_read0: begin
          state <= flow_types_pkg::snap_read1;
        end
        flow_types_pkg::snap_read1: begin
          pop   <= 1'b1;  // id still needed in emit, fifo advances after it
          state <= flow_types_pkg::snap_emit;
        end
        flow_types_pkg::snap_emit: begin
          snap_vld <= 1'b1;
          state    <= flow_types_pkg::snap_idle;
        end
        default: begin
          state <= flow_types_pkg::snap_idle;
        end
      endcase
    end
  end

  // both rams share one read address
  always_ff @(posedge clk) begin
    if (state == flow_types_pkg::snap_idle) begin
      rd_addr <= id[flow_cfg_pkg::addr_w-1:0];
    end
    if (state == flow_types_pkg::snap_emit) begin
      snap.id <= id;
      snap.tx <= tx_dout;
      snap.rx <= rx_dout;
    end
  end

  // each snapshot is a single-cycle pulse, never back to back
  a_snap_pulse : assert property (@(posedge clk) disable iff (!rst_n) snap_vld |=> !snap_vld)
    else $error("snap_vld held for more than one cycle");

endmodule

`default_nettype wire

/* rtl/flow_state_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module flow_state_mem (
  input  logic                           clk,
  input  logic                           rst_n,

  // state words, seq on tx and ack on rx
  input  logic                           tx_state_vld,
  input  logic [flow_cfg_pkg::seq_w-1:0] tx_state,
  input  logic                           rx_state_vld,
  input  logic [flow_cfg_pkg::seq_w-1:0] rx_state,

  // flow table results
  input  logic                           tx_lookup_vld,
  input  flow_types_pkg::lookup_t        tx_lookup,
  input  logic                           rx_lookup_vld,
  input  flow_types_pkg::lookup_t        rx_lookup,

  output logic                           snap_vld,
  output flow_types_pkg::snapshot_t      snap
);

  localparam int lookup_w = $bits(flow_types_pkg::lookup_t);

  logic [flow_cfg_pkg::ts_w-1:0]      ts_cnt;

  logic [flow_cfg_pkg::seq_w-1:0]     tx_state_head, rx_state_head;
  logic                               tx_state_empty, rx_state_empty;
  flow_types_pkg::lookup_t            tx_lookup_head, rx_lookup_head;
  logic                               tx_lookup_empty, rx_lookup_empty;
  logic                               tx_pop, rx_pop;

  logic                               tx_ram_we, rx_ram_we;
  logic [flow_cfg_pkg::addr_w-1:0]    tx_ram_addr, rx_ram_addr, snap_addr;
  flow_types_pkg::tx_hist_t           tx_ram_din, tx_ram_dout, tx_snap_dout;
  flow_types_pkg::rx_hist_t           rx_ram_din, rx_ram_dout, rx_snap_dout;

  logic                               rx_done_vld;
  logic [flow_cfg_pkg::flow_id_w-1:0] rx_done_id, snap_id;
  logic                               snap_id_empty;
  logic                               snap_pop;

  // timestamp, one tick per clock
  always_ff @(posedge clk) begin
    if (!rst_n) ts_cnt <= '0;
    else ts_cnt <= ts_cnt + 1'b1;
  end

  sync_fifo #(.width(flow_cfg_pkg::seq_w), .depth_bits(flow_cfg_pkg::state_fifo_depth_bits))
    tx_state_fifo (.clk, .rst_n, .wr_en(tx_state_vld), .din(tx_state), .rd_en(tx_pop),
                   .dout(tx_state_head), .empty(tx_state_empty));

  sync_fifo #(.width(flow_cfg_pkg::seq_w), .depth_bits(flow_cfg_pkg::state_fifo_depth_bits))
    rx_state_fifo (.clk, .rst_n, .wr_en(rx_state_vld), .din(rx_state), .rd_en(rx_pop),
                   .dout(rx_state_head), .empty(rx_state_empty));

  sync_fifo #(.width(lookup_w), .depth_bits(flow_cfg_pkg::id_fifo_depth_bits))
    tx_lookup_fifo (.clk, .rst_n, .wr_en(tx_lookup_vld), .din(tx_lookup), .rd_en(tx_pop),
                    .dout(tx_lookup_head), .empty(tx_lookup_empty));

  sync_fifo #(.width(lookup_w), .depth_bits(flow_cfg_pkg::id_fifo_depth_bits))
    rx_lookup_fifo (.clk, .rst_n, .wr_en(rx_lookup_vld), .din(rx_lookup), .rd_en(rx_pop),
                    .dout(rx_lookup_head), .empty(rx_lookup_empty));

  // ids of written rx flows waiting for a snapshot
  sync_fifo #(.width(flow_cfg_pkg::flow_id_w), .depth_bits(flow_cfg_pkg::snap_fifo_depth_bits))
    snap_id_fifo (.clk, .rst_n, .wr_en(rx_done_vld), .din(rx_done_id), .rd_en(snap_pop),
                  .dout(snap_id), .empty(snap_id_empty));

  history_ram #(.width($bits(flow_types_pkg::tx_hist_t))) tx_ram (
    .clk, .a_we(tx_ram_we), .a_addr(tx_ram_addr), .a_din(tx_ram_din), .a_dout(tx_ram_dout),
    .b_addr(snap_addr), .b_dout(tx_snap_dout));

  history_ram #(.width($bits(flow_types_pkg::rx_hist_t))) rx_ram (
    .clk, .a_we(rx_ram_we), .a_addr(rx_ram_addr), .a_din(rx_ram_din), .a_dout(rx_ram_dout),
    .b_addr(snap_addr), .b_dout(rx_snap_dout));

  // tx writes never trigger a snapshot
  history_updater #(.hist_len(flow_cfg_pkg::tx_hist_len)) tx_updater (
    .clk, .rst_n, .lookup(tx_lookup_head), .lookup_empty(tx_lookup_empty),
    .state_word(tx_state_head), .state_empty(tx_state_empty), .pop(tx_pop), .ts(ts_cnt),
    .ram_we(tx_ram_we), .ram_addr(tx_ram_addr), .ram_din(tx_ram_din), .ram_dout(tx_ram_dout),
    .done_vld(), .done_id());

  history_updater #(.hist_len(flow_cfg_pkg::rx_hist_len)) rx_updater (
    .clk, .rst_n, .lookup(rx_lookup_head), .lookup_empty(rx_lookup_empty),
    .state_word(rx_state_head), .state_empty(rx_state_empty), .pop(rx_pop), .ts(ts_cnt),
    .ram_we(rx_ram_we), .ram_addr(rx_ram_addr), .ram_din(rx_ram_din), .ram_dout(rx_ram_dout),
    .done_vld(rx_done_vld), .done_id(rx_done_id));

  snapshot_reader snap_reader (
    .clk, .rst_n, .id(snap_id), .id_empty(snap_id_empty), .pop(snap_pop),
    .rd_addr(snap_addr), .tx_dout(tx_snap_dout), .rx_dout(rx_snap_dout),
    .snap_vld, .snap);

endmodule

`default_nettype wire

/* test/tb_stim_table.svh */
`ifndef TB_STIM_TABLE_SVH
`define TB_STIM_TABLE_SVH

// one row per update, word is replaced by a random value on unmatched rows
typedef struct packed {
  logic                               rx;        // 0 tx seq, 1 rx ack
  logic [flow_cfg_pkg::flow_id_w-1:0] id;
  logic                               match;
  logic [flow_cfg_pkg::seq_w-1:0]     word;
  logic                               drain;     // wait for queued snapshots afterwards
  logic [flow_cfg_pkg::seq_w-1:0]     exp_ack0;  // newest ack in the snapshot
  logic [flow_cfg_pkg::seq_w-1:0]     exp_seq0;  // newest tx seq at that ram index
} stim_row_t;

localparam int num_rows = 24;

// columns: rx, id, match, word, drain, exp_ack0, exp_seq0
localparam stim_row_t stim_table [num_rows] = '{
  // tx first, no snapshot may show up
  '{1'b0, 22'h00_0005, 1'b1, 32'h1111_0001, 1'b0, 32'h0, 32'h0},
  '{1'b1, 22'h00_0005, 1'b1, 32'ha000_0001, 1'b1, 32'ha000_0001, 32'h1111_0001},
  '{1'b1, 22'h00_0123, 1'b1, 32'hb000_0001, 1'b1, 32'hb000_0001, 32'h0},
  // history starts to shift
  '{1'b0, 22'h00_0005, 1'b1, 32'h1111_0002, 1'b0, 32'h0, 32'h0},
  '{1'b1, 22'h00_0005, 1'b1, 32'ha000_0002, 1'b1, 32'ha000_0002, 32'h1111_0002},
  // unmatched pairs on both sides
  '{1'b1, 22'h00_0005, 1'b0, 32'h0, 1'b0, 32'h0, 32'h0},
  '{1'b0, 22'h00_0005, 1'b0, 32'h0, 1'b0, 32'h0, 32'h0},
  '{1'b1, 22'h00_0005, 1'b1, 32'ha000_0003, 1'b1, 32'ha000_0003, 32'h1111_0002},
  '{1'b0, 22'h00_0005, 1'b1, 32'h1111_0003, 1'b0, 32'h0, 32'h0},
  '{1'b1, 22'h00_0005, 1'b1, 32'ha000_0004, 1'b1, 32'ha000_0004, 32'h1111_0003},
  // same low 10 bits as 0x005
  '{1'b1, 22'h15_0005, 1'b1, 32'hc000_0001, 1'b1, 32'hc000_0001, 32'h1111_0003},
  '{1'b1, 22'h00_0006, 1'b1, 32'he000_0001, 1'b1, 32'he000_0001, 32'h0},
  '{1'b0, 22'h00_0405, 1'b1, 32'h1111_0004, 1'b0, 32'h0, 32'h0},
  '{1'b1, 22'h00_0005, 1'b1, 32'ha000_0005, 1'b1, 32'ha000_0005, 32'h1111_0004},
  // burst to distinct indexes
  '{1'b0, 22'h00_0012, 1'b1, 32'h1111_0012, 1'b0, 32'h0, 32'h0},
  '{1'b1, 22'h00_0010, 1'b1, 32'h1000_0010, 1'b0, 32'h1000_0010, 32'h0},
  '{1'b1, 22'h00_0011, 1'b1, 32'h1000_0011, 1'b0, 32'h1000_0011, 32'h0},
  '{1'b1, 22'h00_03ff, 1'b0, 32'h0, 1'b0, 32'h0, 32'h0},
  '{1'b1, 22'h00_0012, 1'b1, 32'h1000_0012, 1'b0, 32'h1000_0012, 32'h1111_0012},
  '{1'b1, 22'h00_0013, 1'b1, 32'h1000_0013, 1'b0, 32'h1000_0013, 32'h0},
  '{1'b1, 22'h2a_8014, 1'b1, 32'h1000_0014, 1'b1, 32'h1000_0014, 32'h0},
  '{1'b1, 22'h00_0123, 1'b1, 32'hb000_0002, 1'b0, 32'hb000_0002, 32'h0},
  '{1'b1, 22'h00_0006, 1'b1, 32'he000_0002, 1'b1, 32'he000_0002, 32'h0},
  '{1'b1, 22'h00_0010, 1'b1, 32'h1000_0020, 1'b1, 32'h1000_0020, 32'h0}
};

`endif

/* test/tb_flow_state_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_flow_state_mem;

  `include "tb_stim_table.svh"

  localparam int tx_settle_cycles = 5;  // tx updater back in idle after its write
  localparam int timeout_cycles   = num_rows * 20;
  localparam int ram_words        = 2**flow_cfg_pkg::addr_w;

  // expected snapshot queued when its rx update is driven
  typedef struct packed {
    logic [flow_cfg_pkg::flow_id_w-1:0]                            id;
    logic [flow_cfg_pkg::rx_hist_len-1:0][flow_cfg_pkg::seq_w-1:0] ack;
    logic [flow_cfg_pkg::tx_hist_len-1:0][flow_cfg_pkg::seq_w-1:0] seq;
    logic [flow_cfg_pkg::seq_w-1:0]                                tbl_ack0;
    logic [flow_cfg_pkg::seq_w-1:0]                                tbl_seq0;
    int                                                            rx_n;
    int                                                            tx_n;
  } exp_snap_t;

  logic                           clk;
  logic                           rst_n;
  logic                           tx_state_vld;
  logic [flow_cfg_pkg::seq_w-1:0] tx_state;
  logic                           rx_state_vld;
  logic [flow_cfg_pkg::seq_w-1:0] rx_state;
  logic                           tx_lookup_vld;
  flow_types_pkg::lookup_t        tx_lookup;
  logic                           rx_lookup_vld;
  flow_types_pkg::lookup_t        rx_lookup;
  logic                           snap_vld;
  flow_types_pkg::snapshot_t      snap;

  // reference histories per ram index
  logic [flow_cfg_pkg::rx_hist_len-1:0][flow_cfg_pkg::seq_w-1:0] rx_ack_m [ram_words];
  logic [flow_cfg_pkg::tx_hist_len-1:0][flow_cfg_pkg::seq_w-1:0] tx_seq_m [ram_words];
  int                                                            rx_n_m [ram_words];
  int                                                            tx_n_m [ram_words];

  exp_snap_t   exp_q [$];
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycle_cnt;
  logic [31:0] rng_state = 32'd49767;

  flow_state_mem flow_state_mem_inst (
    .clk, .rst_n, .tx_state_vld, .tx_state, .rx_state_vld, .rx_state,
    .tx_lookup_vld, .tx_lookup, .rx_lookup_vld, .rx_lookup, .snap_vld, .snap);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // newer timestamps must be strictly larger
  task automatic check_order(input string name, input logic [63:0] got, input logic [63:0] bound);
    assert (got > bound) else begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s got %h expected above %h", $time, name, got, bound);
    end
  endtask

  task automatic shift_model(input stim_row_t row, input logic [flow_cfg_pkg::seq_w-1:0] word);
    logic [flow_cfg_pkg::addr_w-1:0] idx;
    idx = row.id[flow_cfg_pkg::addr_w-1:0];
    if (row.rx) begin
      for (int k = flow_cfg_pkg::rx_hist_len - 1; k > 0; k--) begin
        rx_ack_m[idx][k] = rx_ack_m[idx][k-1];
      end
      rx_ack_m[idx][0] = word;
      if (rx_n_m[idx] < flow_cfg_pkg::rx_hist_len) rx_n_m[idx]++;
    end else begin
      for (int k = flow_cfg_pkg::tx_hist_len - 1; k > 0; k--) begin
        tx_seq_m[idx][k] = tx_seq_m[idx][k-1];
      end
      tx_seq_m[idx][0] = word;
      if (tx_n_m[idx] < flow_cfg_pkg::tx_hist_len) tx_n_m[idx]++;
    end
  endtask

  task automatic queue_expected(input stim_row_t row);
    exp_snap_t                       e;
    logic [flow_cfg_pkg::addr_w-1:0] idx;
    idx        = row.id[flow_cfg_pkg::addr_w-1:0];
    e.id       = row.id;  // full id even when the index is shared
    e.ack      = rx_ack_m[idx];
    e.seq      = tx_seq_m[idx];
    e.tbl_ack0 = row.exp_ack0;
    e.tbl_seq0 = row.exp_seq0;
    e.rx_n     = rx_n_m[idx];
    e.tx_n     = tx_n_m[idx];
    exp_q.push_back(e);
  endtask

  task automatic apply_row(input stim_row_t row);
    logic [flow_cfg_pkg::seq_w-1:0] word;
    if (row.match) word = row.word;
    else word = lcg_next();  // discarded word that must never surface
    @(posedge clk);
    #1;
    if (row.rx) begin
      rx_state_vld  = 1'b1;
      rx_state      = word;
      rx_lookup_vld = 1'b1;
      rx_lookup     = '{match: row.match, id: row.id};
    end else begin
      tx_state_vld  = 1'b1;
      tx_state      = word;
      tx_lookup_vld = 1'b1;
      tx_lookup     = '{match: row.match, id: row.id};
    end
    if (row.match) begin
      shift_model(row, word);
      if (row.rx) queue_expected(row);
    end
    @(posedge clk);
    #1;
    rx_state_vld  = 1'b0;
    rx_lookup_vld = 1'b0;
    tx_state_vld  = 1'b0;
    tx_lookup_vld = 1'b0;
    if (!row.rx) repeat (tx_settle_cycles) @(posedge clk);
    if (row.drain) begin
      while (exp_q.size() != 0) @(posedge clk);
    end
  endtask

  task automatic check_snapshot();
    exp_snap_t   e;
    logic [63:0] older;
    string       name;
    assert (exp_q.size() != 0) else begin
      other_errors++;
      $display("unexpected snapshot for flow %h at %0t", snap.id, $time);
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      check_value("snap.id", 64'(snap.id), 64'(e.id));
      for (int k = 0; k < flow_cfg_pkg::rx_hist_len; k++) begin
        name = $sformatf("snap.rx.ack[%0d]", k);
        check_value(name, 64'(snap.rx.ack[k]), (k == 0) ? 64'(e.tbl_ack0) : 64'(e.ack[k]));
        name = $sformatf("snap.rx.ts[%0d]", k);
        if (k >= e.rx_n) check_value(name, snap.rx.ts[k], 64'd0);
        else begin
          older = (k + 1 < e.rx_n) ? snap.rx.ts[k+1] : 64'd0;
          check_order(name, snap.rx.ts[k], older);
        end
      end
      for (int k = 0; k < flow_cfg_pkg::tx_hist_len; k++) begin
        name = $sformatf("snap.tx.seq[%0d]", k);
        check_value(name, 64'(snap.tx.seq[k]), (k == 0) ? 64'(e.tbl_seq0) : 64'(e.seq[k]));
        name = $sformatf("snap.tx.ts[%0d]", k);
        if (k >= e.tx_n) check_value(name, snap.tx.ts[k], 64'd0);
        else begin
          older = (k + 1 < e.tx_n) ? snap.tx.ts[k+1] : 64'd0;
          check_order(name, snap.tx.ts[k], older);
        end
      end
    end
  endtask

  task automatic report_error_counts();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
  endtask

  // outputs settle after the rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      assert (!$isunknown(snap_vld)) else begin
        other_errors++;
        $display("snap_vld is unknown at %0t", $time);
      end
      if (snap_vld === 1'b1) check_snapshot();
    end
  end

  initial begin : stimulus
    rst_n         = 1'b0;
    tx_state_vld  = 1'b0;
    tx_state      = '0;
    rx_state_vld  = 1'b0;
    rx_state      = '0;
    tx_lookup_vld = 1'b0;
    tx_lookup     = '0;
    rx_lookup_vld = 1'b0;
    rx_lookup     = '0;
    for (int i = 0; i < ram_words; i++) begin
      rx_ack_m[i] = '0;
      tx_seq_m[i] = '0;
      rx_n_m[i]   = 0;
      tx_n_m[i]   = 0;
    end
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < num_rows; i++) begin
      apply_row(stim_table[i]);
    end
    repeat (10) @(posedge clk);  // room for a stray late snapshot
    report_error_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    other_errors++;
    $display("timeout after %0d cycles with %0d snapshots still outstanding",
             cycle_cnt, exp_q.size());
    report_error_counts();
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+test
rtl/flow_cfg_pkg.sv
rtl/flow_types_pkg.sv
rtl/sync_fifo.sv
rtl/history_ram.sv
rtl/history_updater.sv
rtl/snapshot_reader.sv
rtl/flow_state_mem.sv
test/tb_flow_state_mem.sv

/* Makefile */
# Verilator build and run for the flow state memory testbench

VERILATOR ?= verilator
TOP       ?= tb_flow_state_mem
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --assert --timing --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
PASS_MSG  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
